// File: verilog/sd_cart_pkg.sv
package sd_cart_pkg;

  ////////////////////////////////
  // Widths
  ////////////////////////////////
  localparam int SNES_ADDR_W       = 24;
  localparam int PSRAM_ADDR_W      = 24;
  localparam int PSRAM_WORD_ADDR_W = PSRAM_ADDR_W - 1;  // Bit 0 becomes the lane select

  typedef logic [SNES_ADDR_W-1:0]       snes_addr_t;
  typedef logic [PSRAM_ADDR_W-1:0]      psram_addr_t;
  typedef logic [PSRAM_WORD_ADDR_W-1:0] psram_word_addr_t;
  typedef logic [7:0]                   byte_t;
  typedef logic [15:0]                  word_t;

  ////////////////////////////////
  // Timing constants
  ////////////////////////////////
  localparam int ROM_CYCLE_LEN     = 7;      // MCU owns the PSRAM for this plus one cycles
  localparam int DELAY_W           = $clog2(ROM_CYCLE_LEN + 1);
  localparam int SNES_DEAD_TIMEOUT = 96000;  // About 1 ms of CLK2
  localparam int DEAD_CNT_W        = $clog2(SNES_DEAD_TIMEOUT + 1);
  localparam int SYNC_DEPTH        = 8;      // Control line history
  localparam int BUS_HIST_DEPTH    = 7;      // Address and data samples 0..6

  localparam psram_addr_t SAVERAM_BASE = 24'hE00000;

  // Mapper selection, anything else maps nothing
  typedef enum logic [2:0] {
    MAPPER_HIROM = 3'd0,
    MAPPER_LOROM = 3'd1
  } mapper_e;

  // MCU port states
  typedef enum logic [2:0] {
    IDLE,
    RD_ADDR,
    RD_END,
    WR_ADDR,
    WR_END
  } mem_fsm_e;

  ////////////////////////////////
  // Structs
  ////////////////////////////////
  typedef struct packed {
    snes_addr_t addr;
    byte_t      data;
    logic       read_n;
    logic       write_n;
    logic       cpu_clk;
    logic       romsel_n;
    logic       rd_start;
    logic       rd_end;
    logic       wr_end;
    logic       cycle_start;
    logic       cycle_end;
    logic       dead;
  } snes_bus_t;

  typedef struct packed {
    psram_addr_t rom_addr;
    logic        is_rom;
    logic        is_saveram;
    logic        is_writable;
    logic        rom_hit;
  } map_result_t;

  typedef struct packed {
    logic        active;
    logic        write;
    psram_addr_t addr;
    byte_t       wdata;
  } mcu_rom_req_t;

endpackage

// File: verilog/snes_bus_frontend.sv
`timescale 1ns/1ps

module snes_bus_frontend import sd_cart_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  snes_addr_t snes_addr,
  input  byte_t      snes_data_in,
  input  logic       snes_read_n,
  input  logic       snes_write_n,
  input  logic       snes_romsel_n,
  input  logic       snes_cpu_clk,
  output snes_bus_t  bus
);

  logic [SYNC_DEPTH-1:0] read_hist;
  logic [SYNC_DEPTH-1:0] write_hist;
  logic [SYNC_DEPTH-1:0] cpu_clk_hist;
  logic [SYNC_DEPTH-1:0] romsel_hist;

  snes_addr_t addr_hist [BUS_HIST_DEPTH];
  byte_t      data_hist [BUS_HIST_DEPTH];

  logic [DEAD_CNT_W-1:0] dead_cnt;
  logic                  dead;
  logic                  cpu_clk_lvl;

  ////////////////////////////////
  // Sample histories
  ////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      read_hist    <= '1;  // Idle bus, strobes quiet after reset
      write_hist   <= '1;
      romsel_hist  <= '1;
      cpu_clk_hist <= '0;
    end else begin
      read_hist    <= {read_hist[SYNC_DEPTH-2:0], snes_read_n};
      write_hist   <= {write_hist[SYNC_DEPTH-2:0], snes_write_n};
      romsel_hist  <= {romsel_hist[SYNC_DEPTH-2:0], snes_romsel_n};
      cpu_clk_hist <= {cpu_clk_hist[SYNC_DEPTH-2:0], snes_cpu_clk};
    end
  end

  // Address and data need more settling time
  always_ff @(posedge clk) begin
    addr_hist[0] <= snes_addr;
    data_hist[0] <= snes_data_in;
    for (int i = 1; i < BUS_HIST_DEPTH; i++) begin
      addr_hist[i] <= addr_hist[i-1];
      data_hist[i] <= data_hist[i-1];
    end
  end

  assign cpu_clk_lvl = cpu_clk_hist[2] & cpu_clk_hist[1];

  ////////////////////////////////
  // SNES alive tracking
  ////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dead_cnt <= '0;
      dead     <= 1'b1;
    end else if (cpu_clk_lvl) begin
      dead_cnt <= '0;
      dead     <= 1'b0;
    end else if (dead_cnt == DEAD_CNT_W'(SNES_DEAD_TIMEOUT)) begin
      dead <= 1'b1;  // Counter parks here
    end else begin
      dead_cnt <= dead_cnt + 1'b1;
    end
  end

  // Edge patterns: two adjacent sample windows must agree
  always_comb begin
    bus.addr     = addr_hist[BUS_HIST_DEPTH-1] & addr_hist[BUS_HIST_DEPTH-2];
    bus.data     = data_hist[BUS_HIST_DEPTH-1] & data_hist[BUS_HIST_DEPTH-2];
    bus.read_n   = read_hist[2] & read_hist[1];
    bus.write_n  = write_hist[2] & write_hist[1];
    bus.cpu_clk  = cpu_clk_lvl;
    bus.romsel_n = romsel_hist[2] & romsel_hist[1];
    bus.rd_start = (read_hist[SYNC_DEPTH-2:1] | read_hist[SYNC_DEPTH-1:2]) == 6'b111100;
    bus.rd_end   = (read_hist[SYNC_DEPTH-2:1] & read_hist[SYNC_DEPTH-1:2]) == 6'b000001;
    bus.wr_end   = (write_hist[SYNC_DEPTH-2:1] & write_hist[SYNC_DEPTH-1:2]) == 6'b000001;
    bus.cycle_start =
      (cpu_clk_hist[SYNC_DEPTH-1:2] & cpu_clk_hist[SYNC_DEPTH-2:1]) == 6'b000011;
    bus.cycle_end =
      (cpu_clk_hist[SYNC_DEPTH-1:2] | cpu_clk_hist[SYNC_DEPTH-2:1]) == 6'b111000;
    bus.dead     = dead;
  end

endmodule

// File: verilog/snes_addr_map.sv
`timescale 1ns/1ps

module snes_addr_map import sd_cart_pkg::*; (
  input  snes_bus_t   bus,
  input  mapper_e     mapper,
  input  psram_addr_t rom_mask,
  input  psram_addr_t saveram_mask,
  output map_result_t map
);

  snes_addr_t  a;
  logic [7:0]  bank;
  psram_addr_t lorom_rom_addr;
  psram_addr_t lorom_sram_addr;
  psram_addr_t hirom_rom_addr;
  psram_addr_t hirom_sram_addr;

  assign a    = bus.addr;
  assign bank = a[23:16];

  // Candidate addresses for both mappers
  assign lorom_rom_addr  = psram_addr_t'({a[22:16], a[14:0]}) & rom_mask;
  assign lorom_sram_addr = SAVERAM_BASE
                         | (psram_addr_t'({a[20:16], a[14:0]}) & saveram_mask);
  assign hirom_rom_addr  = psram_addr_t'(a[21:0]) & rom_mask;
  assign hirom_sram_addr = SAVERAM_BASE
                         | (psram_addr_t'({a[20:16], a[12:0]}) & saveram_mask);

  always_comb begin
    map = '0;
    case (mapper)
      MAPPER_LOROM: begin
        map.is_rom     = a[15];
        map.is_saveram = (bank >= 8'h70) && (bank <= 8'h7D) && !a[15];  // Banks 70-7D low half
        map.rom_addr   = map.is_saveram ? lorom_sram_addr : lorom_rom_addr;
      end
      MAPPER_HIROM: begin
        map.is_rom     = a[22] | a[15];
        // Banks 20-3F and A0-BF at 6000-7FFF
        map.is_saveram = (a[22:21] == 2'b01) && (a[15:13] == 3'b011);
        map.rom_addr   = map.is_saveram ? hirom_sram_addr : hirom_rom_addr;
      end
      default: begin
        map.is_rom     = 1'b0;
        map.is_saveram = 1'b0;
      end
    endcase
    map.is_writable = map.is_saveram;
    map.rom_hit     = map.is_rom | map.is_saveram;
  end

endmodule

// File: verilog/mcu_rom_port.sv
`timescale 1ns/1ps

module mcu_rom_port import sd_cart_pkg::*; (
  input  logic         clk,
  input  logic         arst_n,
  input  logic         mcu_rrq,
  input  logic         mcu_wrq,
  input  psram_addr_t  mcu_addr,
  input  byte_t        mcu_wdata,
  output byte_t        mcu_rdata,
  output logic         mcu_rdy,
  input  snes_bus_t    bus,
  input  logic         rom_hit,
  input  word_t        rom_rdata,
  output mcu_rom_req_t req
);

  mem_fsm_e             state;
  logic [DELAY_W-1:0]   delay;
  logic                 rd_pend;
  logic                 wr_pend;
  logic                 rdy_r;
  logic                 free_strobe;
  logic                 free_slot;
  psram_addr_t          addr_r;
  byte_t                wdata_r;
  byte_t                rdata_r;

  ////////////////////////////////
  // Request latching
  ////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy_r   <= 1'b1;
    end else if (rdy_r && mcu_rrq) begin
      rd_pend <= 1'b1;
      rdy_r   <= 1'b0;
    end else if (rdy_r && mcu_wrq) begin
      wr_pend <= 1'b1;
      rdy_r   <= 1'b0;
    end else if (state == RD_END || state == WR_END) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy_r   <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rdy_r && (mcu_rrq || mcu_wrq)) begin
      addr_r  <= mcu_addr;
      wdata_r <= mcu_wdata;
    end
  end

  // Cycle that started without touching cartridge memory
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) free_strobe <= 1'b0;
    else         free_strobe <= bus.cycle_start & ~rom_hit;
  end

  assign free_slot = bus.cycle_end | free_strobe | bus.dead;

  ////////////////////////////////
  // Slot FSM
  ////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
      delay <= '0;
    end else if (bus.dead && bus.cpu_clk) begin
      state <= IDLE;  // SNES woke up, retry later
    end else begin
      case (state)
        IDLE: begin
          if (free_slot && rd_pend) begin
            state <= RD_ADDR;
            delay <= DELAY_W'(ROM_CYCLE_LEN);
          end else if (free_slot && wr_pend) begin
            state <= WR_ADDR;
            delay <= DELAY_W'(ROM_CYCLE_LEN);
          end
        end
        RD_ADDR, WR_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= (state == RD_ADDR) ? RD_END : WR_END;
        end
        default: state <= IDLE;  // Both END states
      endcase
    end
  end

  // Lane byte follows the PSRAM every read cycle
  always_ff @(posedge clk) begin
    if (state == RD_ADDR) rdata_r <= addr_r[0] ? rom_rdata[7:0] : rom_rdata[15:8];
  end

  assign mcu_rdata  = rdata_r;
  assign mcu_rdy    = rdy_r;
  assign req.active = (state == RD_ADDR) || (state == WR_ADDR);
  assign req.write  = (state == WR_ADDR);
  assign req.addr   = addr_r;
  assign req.wdata  = wdata_r;

endmodule

// File: verilog/psram_arbiter.sv
`timescale 1ns/1ps

module psram_arbiter import sd_cart_pkg::*; (
  input  snes_bus_t        bus,
  input  map_result_t      map,
  input  mcu_rom_req_t     req,
  input  word_t            rom_data_in,
  output psram_word_addr_t rom_addr,
  output word_t            rom_data_out,
  output logic             rom_data_drive,
  output logic             rom_we_n,
  output logic             rom_bhe_n,
  output logic             rom_ble_n,
  output byte_t            snes_data_out,
  output logic             snes_data_drive,
  output logic             snes_databus_oe_n,
  output logic             snes_databus_dir
);

  psram_addr_t sel_addr;
  logic        lane;
  byte_t       wr_byte;
  logic        mcu_wr;
  logic        snes_wr;
  logic        snes_access;

  ////////////////////////////////
  // PSRAM owner select
  ////////////////////////////////
  assign sel_addr = req.active ? req.addr : map.rom_addr;
  assign lane     = sel_addr[0];  // 1 means low byte
  assign rom_addr = sel_addr[PSRAM_ADDR_W-1:1];

  assign rom_bhe_n = lane;
  assign rom_ble_n = ~lane;

  assign mcu_wr  = req.active & req.write;
  assign snes_wr = ~req.active & map.rom_hit & ~bus.write_n;

  assign wr_byte        = req.active ? req.wdata : bus.data;
  assign rom_data_out   = lane ? {8'h00, wr_byte} : {wr_byte, 8'h00};
  assign rom_data_drive = mcu_wr | snes_wr;

  // SNES write only strobes while the CPU clock is high
  always_comb begin
    if (mcu_wr) begin
      rom_we_n = 1'b0;
    end else if (!req.active && map.is_writable && bus.cpu_clk) begin
      rom_we_n = bus.write_n;
    end else begin
      rom_we_n = 1'b1;
    end
  end

  ////////////////////////////////
  // SNES data bus
  ////////////////////////////////
  assign snes_data_out   = lane ? rom_data_in[7:0] : rom_data_in[15:8];
  assign snes_data_drive = ~bus.read_n;

  assign snes_access = ~bus.read_n | ~bus.write_n;

  // Buffer opens only for cartridge memory
  assign snes_databus_oe_n = ~(((map.is_rom & ~bus.romsel_n) | map.is_writable)
                               & snes_access);
  assign snes_databus_dir  = ~bus.read_n;  // 1 drives toward the SNES

endmodule

// File: verilog/sd_cart_top.sv
`timescale 1ns/1ps

module sd_cart_top import sd_cart_pkg::*; (
  input  logic             CLK2,
  input  logic             arst_n,
  // SNES side
  input  snes_addr_t       snes_addr,
  input  byte_t            snes_data_in,
  input  logic             snes_read_n,
  input  logic             snes_write_n,
  input  logic             snes_romsel_n,
  input  logic             snes_cpu_clk,
  output byte_t            snes_data_out,
  output logic             snes_data_drive,
  output logic             snes_databus_oe_n,
  output logic             snes_databus_dir,
  // MCU side
  input  logic             mcu_rrq,
  input  logic             mcu_wrq,
  input  psram_addr_t      mcu_addr,
  input  byte_t            mcu_wdata,
  output byte_t            mcu_rdata,
  output logic             mcu_rdy,
  // Config
  input  mapper_e          mapper,
  input  psram_addr_t      rom_mask,
  input  psram_addr_t      saveram_mask,
  // PSRAM
  output psram_word_addr_t rom_addr,
  input  word_t            rom_data_in,
  output word_t            rom_data_out,
  output logic             rom_data_drive,
  output logic             rom_we_n,
  output logic             rom_bhe_n,
  output logic             rom_ble_n
);

  snes_bus_t    bus;
  map_result_t  map;
  mcu_rom_req_t req;

  snes_bus_frontend u_frontend (
    .clk           (CLK2),
    .arst_n        (arst_n),
    .snes_addr     (snes_addr),
    .snes_data_in  (snes_data_in),
    .snes_read_n   (snes_read_n),
    .snes_write_n  (snes_write_n),
    .snes_romsel_n (snes_romsel_n),
    .snes_cpu_clk  (snes_cpu_clk),
    .bus           (bus)
  );

  snes_addr_map u_addr_map (
    .bus          (bus),
    .mapper       (mapper),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .map          (map)
  );

  mcu_rom_port u_mcu_port (
    .clk       (CLK2),
    .arst_n    (arst_n),
    .mcu_rrq   (mcu_rrq),
    .mcu_wrq   (mcu_wrq),
    .mcu_addr  (mcu_addr),
    .mcu_wdata (mcu_wdata),
    .mcu_rdata (mcu_rdata),
    .mcu_rdy   (mcu_rdy),
    .bus       (bus),
    .rom_hit   (map.rom_hit),
    .rom_rdata (rom_data_in),
    .req       (req)
  );

  psram_arbiter u_arbiter (
    .bus               (bus),
    .map               (map),
    .req               (req),
    .rom_data_in       (rom_data_in),
    .rom_addr          (rom_addr),
    .rom_data_out      (rom_data_out),
    .rom_data_drive    (rom_data_drive),
    .rom_we_n          (rom_we_n),
    .rom_bhe_n         (rom_bhe_n),
    .rom_ble_n         (rom_ble_n),
    .snes_data_out     (snes_data_out),
    .snes_data_drive   (snes_data_drive),
    .snes_databus_oe_n (snes_databus_oe_n),
    .snes_databus_dir  (snes_databus_dir)
  );

endmodule

// File: dv/psram_model.sv
`timescale 1ns/1ps

module psram_model import sd_cart_pkg::*; (
  input  logic             clk,
  input  psram_word_addr_t rom_addr,
  input  word_t            wdata,
  input  logic             drive,
  input  logic             we_n,
  input  logic             bhe_n,
  input  logic             ble_n,
  output word_t            rdata
);

  // Byte addressed, odd byte sits on the low lane
  byte_t mem [psram_addr_t];
  logic  touch;

  initial touch = 1'b0;

  // Lets the testbench place data without a bus cycle
  task automatic preload_byte(input psram_addr_t a, input byte_t d);
    mem[a] = d;
    touch = ~touch;
  endtask

  ////////////////////////////////
  // Write port
  ////////////////////////////////
  always @(posedge clk) begin
    if (!we_n && drive) begin
      if (!ble_n) mem[{rom_addr, 1'b1}] = wdata[7:0];
      if (!bhe_n) mem[{rom_addr, 1'b0}] = wdata[15:8];
      touch = ~touch;  // Refresh the read path
    end
  end

  ////////////////////////////////
  // Read port
  ////////////////////////////////
  always @(rom_addr or touch) begin
    rdata[15:8] = mem.exists({rom_addr, 1'b0}) ? mem[{rom_addr, 1'b0}] : 8'h00;
    rdata[7:0]  = mem.exists({rom_addr, 1'b1}) ? mem[{rom_addr, 1'b1}] : 8'h00;
  end

endmodule

// File: dv/tb_sd_cart.sv
`timescale 1ns/1ps

module tb_sd_cart import sd_cart_pkg::*; ();

  localparam int MCU_TIMEOUT   = 200;  // Cycles for mcu_rdy to come back
  localparam int DRAIN_TIMEOUT = 50;

  typedef struct packed {
    logic        mapped;
    psram_addr_t addr;
    byte_t       data;
    logic        oe_n;
    logic        dir;
  } read_rec_t;

  logic             CLK2;
  logic             arst_n;
  snes_addr_t       snes_addr;
  byte_t            snes_data_in;
  logic             snes_read_n;
  logic             snes_write_n;
  logic             snes_romsel_n;
  logic             snes_cpu_clk;
  byte_t            snes_data_out;
  logic             snes_data_drive;
  logic             snes_databus_oe_n;
  logic             snes_databus_dir;
  logic             mcu_rrq;
  logic             mcu_wrq;
  psram_addr_t      mcu_addr;
  byte_t            mcu_wdata;
  byte_t            mcu_rdata;
  logic             mcu_rdy;
  mapper_e          mapper;
  psram_addr_t      rom_mask;
  psram_addr_t      saveram_mask;
  psram_word_addr_t rom_addr;
  word_t            rom_data_in;
  word_t            rom_data_out;
  logic             rom_data_drive;
  logic             rom_we_n;
  logic             rom_bhe_n;
  logic             rom_ble_n;

  logic [31:0] rng_state;
  logic        traffic_stop;
  read_rec_t   exp_q[$];
  read_rec_t   obs_q[$];
  read_rec_t   want_rec;
  read_rec_t   got_rec;

  sd_cart_top DUT (.*);

  psram_model u_psram (
    .clk      (CLK2),
    .rom_addr (rom_addr),
    .wdata    (rom_data_out),
    .drive    (rom_data_drive),
    .we_n     (rom_we_n),
    .bhe_n    (rom_bhe_n),
    .ble_n    (rom_ble_n),
    .rdata    (rom_data_in)
  );

  initial begin
    CLK2 = 1'b0;
    forever #5 CLK2 = ~CLK2;
  end

  ////////////////////////////////
  // Helpers and reference
  ////////////////////////////////
  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Cartridge select as the SNES decodes it
  function automatic logic romsel_for(snes_addr_t a);
    return ~(a[22] | a[15]);
  endfunction

  function automatic map_result_t ref_map(mapper_e mp, snes_addr_t a,
                                          psram_addr_t rmask, psram_addr_t smask);
    map_result_t r;
    logic [7:0]  bank;
    logic [15:0] off;
    r    = '0;
    bank = a[23:16];
    off  = a[15:0];
    if (mp == MAPPER_LOROM) begin
      r.is_rom     = off >= 16'h8000;
      r.is_saveram = (bank >= 8'h70) && (bank <= 8'h7D) && (off < 16'h8000);
      if (r.is_saveram) r.rom_addr = SAVERAM_BASE | ({4'b0, a[20:16], a[14:0]} & smask);
      else              r.rom_addr = {2'b0, a[22:16], a[14:0]} & rmask;
    end else if (mp == MAPPER_HIROM) begin
      r.is_rom     = a[22] || (off >= 16'h8000);
      r.is_saveram = (bank inside {[8'h20:8'h3F], [8'hA0:8'hBF]})
                     && (off >= 16'h6000) && (off <= 16'h7FFF);
      if (r.is_saveram) r.rom_addr = SAVERAM_BASE | ({6'b0, a[20:16], a[12:0]} & smask);
      else              r.rom_addr = {2'b0, a[21:0]} & rmask;
    end
    r.is_writable = r.is_saveram;
    r.rom_hit     = r.is_rom || r.is_saveram;
    return r;
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp)
      stop_with_error($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_addr(input string name, input psram_addr_t got, input psram_addr_t exp);
    if (got !== exp)
      stop_with_error($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_with_error($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
  endtask

  ////////////////////////////////
  // SNES side
  ////////////////////////////////
  task automatic snes_idle(input int cycles);
    for (int k = 0; k < cycles; k++) begin
      @(negedge CLK2);
      snes_cpu_clk = 1'b0;
      snes_read_n  = 1'b1;
      snes_write_n = 1'b1;
    end
  endtask

  // One CPU cycle of 12 clocks, last driven byte kept as the read result
  task automatic snes_cycle(input snes_addr_t a, input logic is_write, input byte_t d,
                            input logic record);
    read_rec_t last;
    logic      seen;
    last = '0;
    seen = 1'b0;
    for (int k = 0; k < 12; k++) begin
      @(negedge CLK2);
      if (snes_data_drive) begin
        seen      = 1'b1;
        last.addr = {rom_addr, ~rom_ble_n};
        last.data = snes_data_out;
        last.oe_n = snes_databus_oe_n;
        last.dir  = snes_databus_dir;
      end
      case (k)
        0: begin
          snes_addr     = a;
          snes_romsel_n = romsel_for(a);
          snes_data_in  = d;
          snes_cpu_clk  = 1'b0;
        end
        2:  snes_read_n  = is_write;
        6:  snes_cpu_clk = 1'b1;
        7:  snes_write_n = ~is_write;
        9:  snes_read_n  = 1'b1;
        10: snes_write_n = 1'b1;
        default: ;
      endcase
    end
    if (record) begin
      if (!seen) stop_with_error("SNES read cycle ended without the data bus being driven");
      obs_q.push_back(last);
    end
  endtask

  task automatic snes_read_checked(input snes_addr_t a);
    map_result_t m;
    read_rec_t   e;
    m        = ref_map(mapper, a, rom_mask, saveram_mask);
    e.mapped = m.rom_hit;
    e.addr   = m.rom_addr;
    e.data   = m.rom_hit ? u_psram.mem[m.rom_addr] : 8'h00;
    e.oe_n   = ~((m.is_rom & ~romsel_for(a)) | m.is_writable);
    e.dir    = 1'b1;  // Reads point the buffer at the SNES
    exp_q.push_back(e);
    snes_cycle(a, 1'b0, 8'h00, 1'b1);
  endtask

  task automatic saveram_write_check(input snes_addr_t a, input byte_t d);
    map_result_t m;
    m = ref_map(mapper, a, rom_mask, saveram_mask);
    u_psram.preload_byte(m.rom_addr, ~d);
    snes_cycle(a, 1'b1, d, 1'b0);
    snes_idle(4);  // Write strobe trails the cycle
    check_byte("save RAM byte", u_psram.mem[m.rom_addr], d);
    snes_read_checked(a);
  endtask

  ////////////////////////////////
  // MCU side
  ////////////////////////////////
  task automatic wait_ready();
    int n;
    n = 0;
    @(negedge CLK2);
    while (!mcu_rdy) begin
      if (n == MCU_TIMEOUT) stop_with_error("mcu_rdy did not return within the timeout");
      n++;
      @(negedge CLK2);
    end
  endtask

  task automatic mcu_access(input logic is_write, input psram_addr_t a, input byte_t d);
    wait_ready();
    mcu_addr  = a;
    mcu_wdata = d;
    mcu_wrq   = is_write;
    mcu_rrq   = ~is_write;
    @(negedge CLK2);
    mcu_wrq = 1'b0;
    mcu_rrq = 1'b0;
    check_bit("mcu_rdy", mcu_rdy, 1'b0);
    wait_ready();
  endtask

  task automatic mcu_pair_check();
    psram_addr_t a;
    byte_t       d;
    a = psram_addr_t'(rand32());
    d = byte_t'(rand32());
    u_psram.preload_byte(a, ~d);
    mcu_access(1'b1, a, d);
    check_byte("PSRAM byte after MCU write", u_psram.mem[a], d);
    a = psram_addr_t'(rand32());
    d = byte_t'(rand32());
    u_psram.preload_byte(a, d);
    mcu_access(1'b0, a, 8'h00);
    check_byte("mcu_rdata", mcu_rdata, d);
  endtask

  // Scoreboard for SNES reads
  always @(posedge CLK2) begin
    if (obs_q.size() != 0 && exp_q.size() != 0) begin
      got_rec  = obs_q.pop_front();
      want_rec = exp_q.pop_front();
      check_bit("snes_databus_oe_n", got_rec.oe_n, want_rec.oe_n);
      check_bit("snes_databus_dir", got_rec.dir, want_rec.dir);
      if (want_rec.mapped) begin
        check_addr("PSRAM byte address", got_rec.addr, want_rec.addr);
        check_byte("snes_data_out", got_rec.data, want_rec.data);
      end
    end
  end

  ////////////////////////////////
  // Test sequence
  ////////////////////////////////
  initial begin
    snes_addr_t  a;
    map_result_t m;
    byte_t       v;
    int          n;
    rng_state     = 32'h3b045130;
    traffic_stop  = 1'b0;
    snes_addr     = '0;
    snes_data_in  = '0;
    snes_read_n   = 1'b1;
    snes_write_n  = 1'b1;
    snes_romsel_n = 1'b1;
    snes_cpu_clk  = 1'b0;
    mcu_rrq       = 1'b0;
    mcu_wrq       = 1'b0;
    mcu_addr      = '0;
    mcu_wdata     = '0;
    mapper        = MAPPER_LOROM;
    rom_mask      = 24'h0FFFFF;
    saveram_mask  = 24'h001FFF;
    arst_n        = 1'b0;
    repeat (8) @(posedge CLK2);
    @(negedge CLK2);
    arst_n = 1'b1;
    @(negedge CLK2);
    check_bit("mcu_rdy", mcu_rdy, 1'b1);
    check_bit("rom_we_n", rom_we_n, 1'b1);
    check_bit("rom_data_drive", rom_data_drive, 1'b0);
    check_bit("snes_data_drive", snes_data_drive, 1'b0);
    check_bit("snes_databus_oe_n", snes_databus_oe_n, 1'b1);
    check_bit("snes_databus_dir", snes_databus_dir, 1'b0);

    // LoROM reads
    for (int i = 0; i < 24; i++) begin
      a     = snes_addr_t'(rand32());
      a[15] = 1'b1;
      m     = ref_map(mapper, a, rom_mask, saveram_mask);
      u_psram.preload_byte(m.rom_addr, byte_t'(rand32()));
      snes_read_checked(a);
    end

    // HiROM with a small ROM, bit 18 only mirrors
    mapper   = MAPPER_HIROM;
    rom_mask = 24'h03FFFF;
    for (int i = 0; i < 16; i++) begin
      a     = snes_addr_t'(rand32());
      a[22] = 1'b1;
      m     = ref_map(mapper, a, rom_mask, saveram_mask);
      u_psram.preload_byte(m.rom_addr, byte_t'(rand32()));
      snes_read_checked(a);
      snes_read_checked(a ^ 24'h040000);
    end
    for (int i = 0; i < 6; i++) begin
      a        = snes_addr_t'(rand32());
      a[22:21] = 2'b01;
      a[15:13] = 3'b011;
      saveram_write_check(a, byte_t'(rand32()));
    end

    // LoROM save RAM, then ROM space must ignore writes
    mapper   = MAPPER_LOROM;
    rom_mask = 24'h0FFFFF;
    for (int i = 0; i < 12; i++) begin
      a          = snes_addr_t'(rand32());
      a[23:16]   = 8'h70 + 8'(rand32() % 14);
      a[15]      = 1'b0;
      saveram_write_check(a, byte_t'(rand32()));
    end
    for (int i = 0; i < 4; i++) begin
      a     = snes_addr_t'(rand32());
      a[15] = 1'b1;
      m     = ref_map(mapper, a, rom_mask, saveram_mask);
      v     = byte_t'(rand32());
      u_psram.preload_byte(m.rom_addr, v);
      snes_cycle(a, 1'b1, ~v, 1'b0);
      snes_idle(4);
      check_byte("ROM byte after SNES write", u_psram.mem[m.rom_addr], v);
    end
    snes_read_checked(24'h002000);  // Unmapped, buffer stays closed

    // MCU while the SNES runs
    fork
      begin
        for (int k = 0; k < 600 && !traffic_stop; k++) begin
          a = k[0] ? 24'h002000 : (snes_addr_t'(rand32()) | 24'h008000);
          snes_cycle(a, 1'b0, 8'h00, 1'b0);
        end
      end
      begin
        for (int i = 0; i < 8; i++) mcu_pair_check();
        traffic_stop = 1'b1;
      end
    join

    // Stopped CPU clock, SNES declared dead
    snes_idle(SNES_DEAD_TIMEOUT + 16);
    for (int i = 0; i < 8; i++) mcu_pair_check();

    n = 0;
    while (obs_q.size() != 0) begin
      if (n == DRAIN_TIMEOUT) stop_with_error("SNES read results were never compared");
      n++;
      @(posedge CLK2);
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: flist.f
verilog/sd_cart_pkg.sv
verilog/snes_bus_frontend.sv
verilog/snes_addr_map.sv
verilog/mcu_rom_port.sv
verilog/psram_arbiter.sv
verilog/sd_cart_top.sv
dv/psram_model.sv
dv/tb_sd_cart.sv

// File: Bender.yml
package:
  name: sd_cart

sources:
  - verilog/sd_cart_pkg.sv
  - verilog/snes_bus_frontend.sv
  - verilog/snes_addr_map.sv
  - verilog/mcu_rom_port.sv
  - verilog/psram_arbiter.sv
  - verilog/sd_cart_top.sv
  - target: test
    files:
      - dv/psram_model.sv
      - dv/tb_sd_cart.sv
